// File: hdl/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

  //**********************************************************************
  // Command frame layout
  //**********************************************************************

  // Full command word as accepted on cmd_in
  localparam int CMD_WIDTH = 12;

  // Byte returned by a read
  localparam int READ_WIDTH = 8;

  // Register address inside the slave
  localparam int ADDR_WIDTH = 3;

  localparam int OP_BIT   = CMD_WIDTH - 1;           // Set for write
  localparam int ADDR_MSB = OP_BIT - 1;              // Address sits under the op bit

  // A read only sends the op bit and the address
  localparam int READ_HDR_BITS = 1 + ADDR_WIDTH;

  //**********************************************************************
  // Operation encoding
  //**********************************************************************

  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

endpackage

`default_nettype wire

// File: hdl/spi_timing_pkg.sv
`default_nettype none

package spi_timing_pkg;

  //**********************************************************************
  // Serial clock shape in clk cycles
  //**********************************************************************

  localparam int SCLK_HALF  = 4;                     // Low time and high time of sclk
  localparam int BIT_CYCLES = 2 * SCLK_HALF;         // One full sclk period

  // Gap between read header and read data, sclk held low
  localparam int TURN_CYCLES = 16;

  // Engine cycle counter covers both a bit period and the turnaround
  localparam int CNT_WIDTH = $clog2(TURN_CYCLES + 1);

endpackage

`default_nettype wire

// File: hdl/spi_cmd_decode.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_decode
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [spi_cmd_pkg::CMD_WIDTH-1:0] cmd_in,
  input  logic                            cmd_vld,
  input  logic                            done,
  output logic                            cmd_rdy,
  output logic                            start,
  output spi_cmd_pkg::op_e                op,
  output logic [spi_cmd_pkg::CMD_WIDTH-1:0] frame
);

  import spi_cmd_pkg::*;

  logic busy;
  logic accept;

  //**********************************************************************
  // Handshake
  //**********************************************************************

  // The engine reports done in the cycle cs rises, so ready opens right then
  assign cmd_rdy = ~busy | done;
  assign accept  = cmd_vld & cmd_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy  <= 1'b0;
      start <= 1'b0;
    end
    else
    begin
      start <= accept;                                 // Engine kicks off next cycle
      if (accept)
      begin
        busy <= 1'b1;
      end
      else if (done)
      begin
        busy <= 1'b0;
      end
    end
  end

  //**********************************************************************
  // Command register
  //**********************************************************************

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      frame <= cmd_in;                                 // Held until the next acceptance
      op    <= op_e'(cmd_in[OP_BIT]);
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_shift_engine.sv
`timescale 1ns/1ns
`default_nettype none

module spi_shift_engine
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start,
  input  spi_cmd_pkg::op_e                op,
  input  logic [spi_cmd_pkg::CMD_WIDTH-1:0] frame,
  output logic                            cs,
  output logic                            sclk,
  output logic                            mosi,
  output logic                            done,
  output logic                            sample,
  output logic                            rx_done
);

  import spi_cmd_pkg::*;
  import spi_timing_pkg::*;

  typedef enum logic [1:0]
  {
    S_IDLE,
    S_OUT,
    S_TURN,
    S_IN
  } state_e;

  typedef logic [CNT_WIDTH-1:0]          cnt_t;
  typedef logic [$clog2(CMD_WIDTH)-1:0] bit_cnt_t;

  state_e                 state;
  cnt_t                   cnt;                         // Cycles inside a bit or the turnaround
  bit_cnt_t               bit_cnt;                     // Bits finished in the current phase
  bit_cnt_t               out_last;
  logic [CMD_WIDTH-1:0]   shift_q;
  logic                   half_end;
  logic                   bit_end;

  assign out_last = (op == OP_WRITE) ? bit_cnt_t'(CMD_WIDTH - 1)
                                     : bit_cnt_t'(READ_HDR_BITS - 1);

  assign half_end = (cnt == cnt_t'(SCLK_HALF - 1));   // sclk rises on this edge
  assign bit_end  = (cnt == cnt_t'(BIT_CYCLES - 1));  // sclk falls on this edge

  // Capture takes miso on the same edge that raises sclk
  assign sample = (state == S_IN) & half_end;

  //**********************************************************************
  // Phase sequencing and serial outputs
  //**********************************************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= S_IDLE;
      cnt     <= '0;
      bit_cnt <= '0;
      cs      <= 1'b1;
      sclk    <= 1'b0;
      mosi    <= 1'b0;
      done    <= 1'b0;
      rx_done <= 1'b0;
    end
    else
    begin
      done    <= 1'b0;
      rx_done <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (start)
          begin
            state   <= S_OUT;
            cs      <= 1'b0;
            mosi    <= frame[CMD_WIDTH-1];              // First bit goes out with cs
            cnt     <= '0;
            bit_cnt <= '0;
          end
        end
        S_OUT:
        begin
          if (half_end)
          begin
            sclk <= 1'b1;
            cnt  <= cnt + 1'b1;
          end
          else if (bit_end)
          begin
            sclk <= 1'b0;
            cnt  <= '0;
            if (bit_cnt == out_last)
            begin
              bit_cnt <= '0;
              mosi    <= 1'b0;
              if (op == OP_WRITE)
              begin
                state <= S_IDLE;
                cs    <= 1'b1;
                done  <= 1'b1;
              end
              else
              begin
                state <= S_TURN;
              end
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              mosi    <= shift_q[CMD_WIDTH-1];
            end
          end
          else
          begin
            cnt <= cnt + 1'b1;
          end
        end
        S_TURN:
        begin
          if (cnt == cnt_t'(TURN_CYCLES - 1))
          begin
            state <= S_IN;
            cnt   <= '0;
          end
          else
          begin
            cnt <= cnt + 1'b1;
          end
        end
        S_IN:
        begin
          if (half_end)
          begin
            sclk <= 1'b1;
            cnt  <= cnt + 1'b1;
          end
          else if (bit_end)
          begin
            sclk <= 1'b0;
            cnt  <= '0;
            if (bit_cnt == bit_cnt_t'(READ_WIDTH - 1))
            begin
              bit_cnt <= '0;
              state   <= S_IDLE;
              cs      <= 1'b1;
              done    <= 1'b1;
              rx_done <= 1'b1;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          else
          begin
            cnt <= cnt + 1'b1;
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  //**********************************************************************
  // Transmit shifter
  //**********************************************************************

  always_ff @(posedge clk)
  begin
    if ((state == S_IDLE) && start)
    begin
      shift_q <= frame << 1;                           // MSB already on mosi
    end
    else if ((state == S_OUT) && bit_end)
    begin
      shift_q <= shift_q << 1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_read_capture.sv
`timescale 1ns/1ns
`default_nettype none

module spi_read_capture
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             miso,
  input  logic                             sample,
  input  logic                             rx_done,
  output logic                             read_vld,
  output logic [spi_cmd_pkg::READ_WIDTH-1:0] read_data
);

  import spi_cmd_pkg::*;

  logic [READ_WIDTH-1:0] shift_q;

  //**********************************************************************
  // Receive shifter
  //**********************************************************************

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      shift_q <= {shift_q[READ_WIDTH-2:0], miso};      // First bit ends up as MSB
    end
  end

  //**********************************************************************
  // Result register
  //**********************************************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_vld  <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      read_vld <= rx_done;                             // One cycle per finished read
      if (rx_done)
      begin
        read_data <= shift_q;                          // Kept until the next read ends
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_cmd_master.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_master
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [spi_cmd_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                             cmd_vld,
  output logic                             cmd_rdy,
  output logic                             cs,
  output logic                             sclk,
  output logic                             mosi,
  input  logic                             miso,
  output logic                             read_vld,
  output logic [spi_cmd_pkg::READ_WIDTH-1:0] read_data
);

  import spi_cmd_pkg::*;

  logic                 start;
  op_e                  op;
  logic [CMD_WIDTH-1:0] frame;
  logic                 done;
  logic                 sample;
  logic                 rx_done;

  //**********************************************************************
  // Command side
  //**********************************************************************

  spi_cmd_decode spi_cmd_decode_i
  (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .done    (done),
    .cmd_rdy (cmd_rdy),
    .start   (start),
    .op      (op),
    .frame   (frame)
  );

  //**********************************************************************
  // Serial side
  //**********************************************************************

  spi_shift_engine spi_shift_engine_i
  (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .op      (op),
    .frame   (frame),
    .cs      (cs),
    .sclk    (sclk),
    .mosi    (mosi),
    .done    (done),
    .sample  (sample),
    .rx_done (rx_done)
  );

  spi_read_capture spi_read_capture_i
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .miso      (miso),                                 // Straight from the pin
    .sample    (sample),
    .rx_done   (rx_done),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

// File: tests/spi_cmd_master_assert.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_master_assert
(
  input logic clk,
  input logic rst_n,
  input logic cs,
  input logic sclk,
  input logic mosi,
  input logic cmd_rdy,
  input logic read_vld
);

  int fail_cnt;                                        // Read back by the testbench

  //**********************************************************************
  // Serial protocol
  //**********************************************************************

  idle_sclk_low: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
  else
  begin
    $error("sclk is high while cs is high");
    fail_cnt++;
  end

  mosi_hold: assert property (@(posedge clk) disable iff (!rst_n) sclk |-> $stable(mosi))
  else
  begin
    $error("mosi changed while sclk is high");
    fail_cnt++;
  end

  //**********************************************************************
  // Handshake and result
  //**********************************************************************

  busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n) !cs |-> !cmd_rdy)
  else
  begin
    $error("cmd_rdy is high during a transaction");
    fail_cnt++;
  end

  vld_single: assert property (@(posedge clk) disable iff (!rst_n) read_vld |=> !read_vld)
  else
  begin
    $error("read_vld stayed high for two cycles");
    fail_cnt++;
  end

endmodule

bind spi_cmd_master spi_cmd_master_assert spi_cmd_master_assert_i
(
  .clk      (clk),
  .rst_n    (rst_n),
  .cs       (cs),
  .sclk     (sclk),
  .mosi     (mosi),
  .cmd_rdy  (cmd_rdy),
  .read_vld (read_vld)
);

`default_nettype wire

// File: tests/spi_cmd_master_tb.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_master_tb;

  import spi_cmd_pkg::*;
  import spi_timing_pkg::*;

  // Longest frame plus handshake slack, for up to 40 commands
  localparam int CMD_CYCLES = READ_HDR_BITS * BIT_CYCLES + TURN_CYCLES
                              + READ_WIDTH * BIT_CYCLES + 18;
  localparam int MAX_CYCLES = 40 * CMD_CYCLES + 800;
  localparam int MEM_DEPTH  = 1 << ADDR_WIDTH;

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  cs;
  logic                  sclk;
  logic                  mosi;
  logic                  miso;
  logic                  read_vld;
  logic [READ_WIDTH-1:0] read_data;

  logic [READ_WIDTH-1:0] mem [0:MEM_DEPTH-1];          // Slave registers
  logic [READ_WIDTH-1:0] exp_mem [0:MEM_DEPTH-1];      // Scoreboard copy
  logic [CMD_WIDTH-1:0]  rx_frame;
  logic [CMD_WIDTH-1:0]  last_frame;
  logic [READ_WIDTH-1:0] tx_byte;
  logic                  rd_mode;
  logic [CMD_WIDTH-1:0]  bp_a;
  logic [CMD_WIDTH-1:0]  bp_b;
  logic [31:0]           rng;
  int                    bits;
  int                    last_bits;
  int                    frames;
  int                    vld_cnt;
  int                    cycles;
  int                    n0;
  int                    test_errs;
  int                    total_errs;
  int                    tests_run;
  int                    tests_failed;

  spi_cmd_master spi_cmd_master_i
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .cs        (cs),
    .sclk      (sclk),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [READ_WIDTH-1:0] fill_byte(input int addr);
    return READ_WIDTH'(addr * 37 + 5);
  endfunction

  task automatic step();
    @(posedge clk);
    #10;                                               // Inputs move after the edge
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    assert (exp_v == act_v)
    else
    begin
      $display("Mismatch %s: expected %0h, actual %0h", name, exp_v, act_v);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0)
    begin
      $display("%s: passed", name);
    end
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic run_cmd(input string name, input logic [CMD_WIDTH-1:0] cmd);
    int                    f0;
    int                    v0;
    logic [ADDR_WIDTH-1:0] addr;
    logic [READ_WIDTH-1:0] data;
    f0   = frames;
    v0   = vld_cnt;
    addr = cmd[ADDR_MSB -: ADDR_WIDTH];
    data = cmd[READ_WIDTH-1:0];
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
    begin
      step();
    end
    step();                                            // Taken on this edge
    cmd_vld = 1'b0;
    while (frames == f0)
    begin
      step();
    end
    step();
    step();                                            // read_vld has come and gone
    if (cmd[OP_BIT])
    begin
      check_val({name, " bits"}, CMD_WIDTH, last_bits);
      check_val({name, " frame"}, 32'(cmd), 32'(last_frame));
      check_val({name, " stored"}, 32'(data), 32'(mem[addr]));
      exp_mem[addr] = data;
    end
    else
    begin
      check_val({name, " bits"}, READ_HDR_BITS, last_bits);
      check_val({name, " header"}, 32'(cmd[CMD_WIDTH-1 -: READ_HDR_BITS]),
                32'(last_frame[READ_HDR_BITS-1:0]));
      check_val({name, " read_vld pulses"}, 1, vld_cnt - v0);
      check_val({name, " read_data"}, 32'(exp_mem[addr]), 32'(read_data));
    end
  endtask

  //**********************************************************************
  // Clock, cycle limit and slave model
  //**********************************************************************

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (read_vld)
    begin
      vld_cnt <= vld_cnt + 1;
    end
    if (cycles == MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles, a transaction never finished", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial
  begin
    miso <= 1'b0;
    for (int i = 0; i < MEM_DEPTH; i++)
    begin
      mem[ADDR_WIDTH'(i)] = fill_byte(i);
    end
    forever
    begin
      @(negedge cs);
      bits     = 0;
      rx_frame = '0;
      rd_mode  = 1'b0;
      while (!cs)
      begin
        @(sclk or cs);
        if (!cs && sclk && !rd_mode)
        begin
          rx_frame = {rx_frame[CMD_WIDTH-2:0], mosi};
          bits++;
          if ((bits == READ_HDR_BITS) && !rx_frame[READ_HDR_BITS-1])
          begin
            rd_mode = 1'b1;                            // Header done, answer follows
            tx_byte = mem[rx_frame[ADDR_WIDTH-1:0]];
          end
        end
        else if (!cs && !sclk && rd_mode)
        begin
          miso <= #10 tx_byte[READ_WIDTH-1];
          tx_byte = tx_byte << 1;
        end
      end
      if (!rd_mode && (bits == CMD_WIDTH) && rx_frame[OP_BIT])
      begin
        mem[rx_frame[ADDR_MSB -: ADDR_WIDTH]] = rx_frame[READ_WIDTH-1:0];
      end
      last_bits  = bits;
      last_frame = rx_frame;
      frames++;
    end
  end

  //**********************************************************************
  // Stimulus
  //**********************************************************************

  initial
  begin
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rng     = 32'd78124;
    for (int i = 0; i < MEM_DEPTH; i++)
    begin
      exp_mem[ADDR_WIDTH'(i)] = fill_byte(i);
    end
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b1;
    step();

    check_val("reset cs", 1, 32'(cs));
    check_val("reset sclk", 0, 32'(sclk));
    check_val("reset mosi", 0, 32'(mosi));
    check_val("reset cmd_rdy", 1, 32'(cmd_rdy));
    check_val("reset read_vld", 0, 32'(read_vld));
    finish_test("reset");

    run_cmd("write", {1'b1, 3'd6, 8'h5A});
    finish_test("write");

    run_cmd("read", {1'b0, 3'd6, 8'h00});
    run_cmd("read", {1'b0, 3'd1, 8'h00});              // Untouched entry keeps the fill
    finish_test("read");

    // cmd_vld stays up through the first frame while cmd_in moves on
    n0      = frames;
    bp_a    = {1'b1, 3'd5, 8'h3C};
    bp_b    = {1'b1, 3'd2, 8'hC3};
    cmd_in  = bp_a;
    cmd_vld = 1'b1;
    step();
    cmd_in = bp_b;
    check_val("backpressure cmd_rdy", 0, 32'(cmd_rdy));
    while (frames == n0)
    begin
      step();
    end
    check_val("backpressure first", 32'(bp_a), 32'(last_frame));
    exp_mem[5] = 8'h3C;
    step();                                            // bp_b taken as cs rises
    cmd_vld = 1'b0;
    cmd_in  = '1;
    while (frames == n0 + 1)
    begin
      step();
    end
    check_val("backpressure second", 32'(bp_b), 32'(last_frame));
    exp_mem[2] = 8'hC3;
    repeat (4 * BIT_CYCLES) step();
    check_val("backpressure frames", n0 + 2, frames);
    finish_test("backpressure");

    for (int i = 0; i < 30; i++)
    begin
      rng = xorshift(rng);
      run_cmd("random", rng[CMD_WIDTH-1:0]);
    end
    finish_test("random");

    check_val("protocol", 0, spi_cmd_master_i.spi_cmd_master_assert_i.fail_cnt);
    finish_test("protocol");

    $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
             total_errs);
    if (total_errs == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hdl/spi_cmd_pkg.sv
hdl/spi_timing_pkg.sv
hdl/spi_cmd_decode.sv
hdl/spi_shift_engine.sv
hdl/spi_read_capture.sv
hdl/spi_cmd_master.sv
tests/spi_cmd_master_assert.sv
tests/spi_cmd_master_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module spi_cmd_master_tb -f files.f

out=$(./obj_dir/Vspi_cmd_master_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1
